/* verilog/io_defs.svh */
// Bus widths, slave select bit, receive FIFO depth and SPI clock divider macros
`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// ******************************
// Host bus
// ******************************
`define IO_ADDR_W 8
`define IO_DATA_W 32

// Address bit that picks the slave, 0 is the system controller and 1 is SPI
`define IO_SEL_BIT 7

// ******************************
// Peripherals
// ******************************
`define IO_GPIO_W 32

// Received bytes held before overflow
`define IO_FIFO_DEPTH 4

// Clock cycles per SCLK half period
`define IO_SPI_HALF 4

`endif

/* verilog/io_pkg.sv */
// Shared host address union and register index enumerations
`include "io_defs.svh"

package io_pkg;

   // One address word, seen by each slave with its own register spacing
   typedef union packed {
      logic [`IO_ADDR_W-1:0] raw;
      struct packed {
         logic       sel;
         logic [1:0] rsvd;
         logic [2:0] idx;
         logic [1:0] ofs;
      } sys;
      // SPI registers sit 8 bytes apart, bit 2 marks the upper half
      struct packed {
         logic       sel;
         logic       rsvd;
         logic [2:0] idx;
         logic       half;
         logic [1:0] ofs;
      } spi;
   } io_addr_u;

   typedef enum logic [2:0] {
      GPIO_OUT = 3'd0, GPIO_IN  = 3'd1, MTIME_LO = 3'd2, MTIME_HI = 3'd3,
      MTCMP_LO = 3'd4, MTCMP_HI = 3'd5, SWIRQ    = 3'd6
   } sys_reg_e;

   typedef enum logic [2:0] {CTRL = 3'd0, STATUS = 3'd1, DATA = 3'd2, CS = 3'd3} spi_reg_e;

endpackage

/* verilog/sys_ctrl.sv */
// System controller with GPIO, 64-bit timer and compare, software interrupt bits
`timescale 1ns/100ps
`include "io_defs.svh"

module sys_ctrl (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_stb,
   input  logic                  i_we,
   input  io_pkg::io_addr_u      i_addr,
   input  logic [`IO_DATA_W-1:0] i_wdata,
   input  logic [`IO_GPIO_W-1:0] i_gpio,
   output logic                  o_ack,
   output logic [`IO_DATA_W-1:0] o_rdata,
   output logic [`IO_GPIO_W-1:0] o_gpio,
   output logic                  o_timer_irq,
   output logic                  o_sw_irq3,
   output logic                  o_sw_irq4
);

   import io_pkg::*;

   sys_reg_e              reg_idx;
   logic                  wr_en;
   logic [63:0]           mtime_q;
   logic [63:0]           mtcmp_q;
   logic [1:0]            swirq_q;
   logic [`IO_DATA_W-1:0] rdata_d;

   assign reg_idx = sys_reg_e'(i_addr.sys.idx);
   // Writes land on the same edge that raises the ack
   assign wr_en   = i_stb & i_we & ~o_ack;

   // ******************************
   // Registers
   // ******************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_ack       <= 1'b0;
         o_gpio      <= '0;
         mtime_q     <= '0;
         mtcmp_q     <= '1;
         swirq_q     <= 2'b00;
         o_timer_irq <= 1'b0;
      end else begin
         o_ack       <= i_stb & ~o_ack;
         mtime_q     <= mtime_q + 64'd1;
         // Level, stays up until the compare value moves past the count
         o_timer_irq <= (mtime_q >= mtcmp_q);
         if (wr_en) begin
            case (reg_idx)
               GPIO_OUT: o_gpio <= i_wdata[`IO_GPIO_W-1:0];
               MTCMP_LO: mtcmp_q[31:0] <= i_wdata;
               MTCMP_HI: mtcmp_q[63:32] <= i_wdata;
               SWIRQ:    swirq_q <= i_wdata[1:0];
               default: ;
            endcase
         end
      end
   end

   assign o_sw_irq3 = swirq_q[0];
   assign o_sw_irq4 = swirq_q[1];

   // ******************************
   // Read mux
   // ******************************
   always_comb begin
      case (reg_idx)
         GPIO_OUT: rdata_d = `IO_DATA_W'(o_gpio);
         GPIO_IN:  rdata_d = `IO_DATA_W'(i_gpio);
         MTIME_LO: rdata_d = mtime_q[31:0];
         MTIME_HI: rdata_d = mtime_q[63:32];
         MTCMP_LO: rdata_d = mtcmp_q[31:0];
         MTCMP_HI: rdata_d = mtcmp_q[63:32];
         SWIRQ:    rdata_d = `IO_DATA_W'(swirq_q);
         // Unmapped index reads as zero
         default:  rdata_d = '0;
      endcase
   end

   // Sampled with the ack, so the host sees it during the ack cycle
   always_ff @(posedge i_clk) begin
      if (i_stb && !o_ack)
         o_rdata <= rdata_d;
   end

endmodule

/* verilog/spi_shifter.sv */
// SPI mode-0 byte shifter with clock divider, MSB first, pushing each received byte
`timescale 1ns/100ps
`include "io_defs.svh"

module spi_shifter (
   input  logic       i_clk,
   input  logic       i_rst_n,
   input  logic       i_tx_start,
   input  logic [7:0] i_tx_byte,
   input  logic       i_miso,
   output logic       o_busy,
   output logic       o_push,
   output logic [7:0] o_rx_byte,
   output logic       o_sclk,
   output logic       o_mosi
);

   localparam int unsigned DIV_W = $clog2(`IO_SPI_HALF);
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`IO_SPI_HALF - 1);

   logic [DIV_W-1:0] div_q;
   logic [3:0]       half_q;
   logic [7:0]       tx_sh_q;
   logic [7:0]       rx_sh_q;
   logic             half_end;
   logic             last_half;

   assign half_end  = (div_q == DIV_LAST);
   assign last_half = (half_q == 4'd15);

   // ******************************
   // Divider and half period count
   // ******************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_busy <= 1'b0;
         o_sclk <= 1'b0;
         div_q  <= '0;
         half_q <= 4'd0;
      end else if (!o_busy) begin
         if (i_tx_start) begin
            o_busy <= 1'b1;
            div_q  <= '0;
            half_q <= 4'd0;
         end
      end else begin
         div_q <= half_end ? '0 : div_q + 1'b1;
         if (half_end) begin
            half_q <= half_q + 4'd1;
            // 16 halves make 8 full SCLK periods
            if (last_half) begin
               o_busy <= 1'b0;
               o_sclk <= 1'b0;
            end else begin
               o_sclk <= ~o_sclk;
            end
         end
      end
   end

   // ******************************
   // Data shift
   // ******************************
   always_ff @(posedge i_clk) begin
      if (!o_busy && i_tx_start) begin
         tx_sh_q <= i_tx_byte;
      end else if (o_busy && half_end) begin
         // Even half ends on rising SCLK, odd half on falling SCLK
         if (!half_q[0])
            rx_sh_q <= {rx_sh_q[6:0], i_miso};
         else if (!last_half)
            tx_sh_q <= {tx_sh_q[6:0], 1'b0};
      end
   end

   assign o_mosi    = tx_sh_q[7];
   assign o_rx_byte = rx_sh_q;
   // Final busy cycle, all 8 bits are in
   assign o_push    = o_busy & half_end & last_half;

endmodule

/* verilog/spi_rx_fifo.sv */
// Synchronous receive FIFO for SPI bytes with head output and level flags
`timescale 1ns/100ps
`include "io_defs.svh"

module spi_rx_fifo (
   input  logic       i_clk,
   input  logic       i_rst_n,
   input  logic       i_push,
   input  logic [7:0] i_data,
   input  logic       i_pop,
   output logic [7:0] o_data,
   output logic       o_empty,
   output logic       o_full
);

   localparam int unsigned AW = $clog2(`IO_FIFO_DEPTH);
   localparam logic [AW:0] CNT_FULL = (AW + 1)'(`IO_FIFO_DEPTH);

   logic [7:0]  mem_q [`IO_FIFO_DEPTH];
   logic [AW-1:0] wr_q;
   logic [AW-1:0] rd_q;
   logic [AW:0]   cnt_q;
   logic          do_push;
   logic          do_pop;

   // Push into full and pop from empty are both dropped
   assign do_push = i_push & ~o_full;
   assign do_pop  = i_pop & ~o_empty;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_q  <= '0;
         rd_q  <= '0;
         cnt_q <= '0;
      end else begin
         if (do_push)
            wr_q <= wr_q + 1'b1;
         if (do_pop)
            rd_q <= rd_q + 1'b1;
         if (do_push && !do_pop)
            cnt_q <= cnt_q + 1'b1;
         else if (do_pop && !do_push)
            cnt_q <= cnt_q - 1'b1;
      end
   end

   // Storage
   always_ff @(posedge i_clk) begin
      if (do_push)
         mem_q[wr_q] <= i_data;
   end

   assign o_data  = mem_q[rd_q];
   assign o_empty = (cnt_q == '0);
   assign o_full  = (cnt_q == CNT_FULL);

endmodule

/* verilog/spi_host_regs.sv */
// SPI bus registers with control, status, data, chip select and split read redirect
`timescale 1ns/100ps
`include "io_defs.svh"

module spi_host_regs (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_stb,
   input  logic                  i_we,
   input  io_pkg::io_addr_u      i_addr,
   input  logic [`IO_DATA_W-1:0] i_wdata,
   input  logic                  i_busy,
   input  logic                  i_empty,
   input  logic                  i_full,
   input  logic                  i_push,
   input  logic [7:0]            i_rx_data,
   output logic                  o_ack,
   output logic [`IO_DATA_W-1:0] o_rdata,
   output logic                  o_tx_start,
   output logic [7:0]            o_tx_byte,
   output logic                  o_pop,
   output logic                  o_cs_n,
   output logic                  o_irq
);

   import io_pkg::*;

   spi_reg_e              reg_idx;
   logic                  acc;
   logic                  wr_en;
   logic                  busy;
   logic                  irq_en_q;
   logic                  wcol_q;
   logic                  ovf_q;
   logic [`IO_DATA_W-1:0] rdata_d;

   // Second half of a split wide read lands on CTRL, so DATA is never popped twice
   assign reg_idx = (i_addr.spi.half && !i_we) ? CTRL : spi_reg_e'(i_addr.spi.idx);
   assign acc     = i_stb & ~o_ack;
   assign wr_en   = acc & i_we;
   // A start still in flight counts as busy
   assign busy    = i_busy | o_tx_start;
   assign o_pop   = acc & ~i_we & (reg_idx == DATA);
   assign o_irq   = irq_en_q & ~i_empty;

   // ******************************
   // Control and sticky status
   // ******************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_ack      <= 1'b0;
         o_tx_start <= 1'b0;
         o_cs_n     <= 1'b1;
         irq_en_q   <= 1'b0;
         wcol_q     <= 1'b0;
         ovf_q      <= 1'b0;
      end else begin
         o_ack      <= acc;
         o_tx_start <= wr_en & (reg_idx == DATA) & ~busy;
         if (wr_en) begin
            case (reg_idx)
               CTRL:   irq_en_q <= i_wdata[0];
               STATUS: begin
                  if (i_wdata[3]) wcol_q <= 1'b0;
                  if (i_wdata[4]) ovf_q <= 1'b0;
               end
               DATA:   if (busy) wcol_q <= 1'b1;
               CS:     o_cs_n <= i_wdata[0];
               default: ;
            endcase
         end
         // Overflow set wins over a clear in the same cycle
         if (i_push && i_full)
            ovf_q <= 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (wr_en && reg_idx == DATA && !busy)
         o_tx_byte <= i_wdata[7:0];
   end

   // ******************************
   // Read data
   // ******************************
   always_comb begin
      case (reg_idx)
         CTRL:    rdata_d = `IO_DATA_W'(irq_en_q);
         STATUS:  rdata_d = `IO_DATA_W'({ovf_q, wcol_q, i_busy, i_full, i_empty});
         DATA:    rdata_d = `IO_DATA_W'(i_rx_data);
         CS:      rdata_d = `IO_DATA_W'(o_cs_n);
         default: rdata_d = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (acc)
         o_rdata <= rdata_d;
   end

endmodule

/* verilog/io_subsys_top.sv */
// IO subsystem top level with slave decode, ack and read data return, instances
`timescale 1ns/100ps
`include "io_defs.svh"

module io_subsys_top (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_stb,
   input  logic                  i_we,
   input  io_pkg::io_addr_u      i_addr,
   input  logic [`IO_DATA_W-1:0] i_wdata,
   input  logic [`IO_GPIO_W-1:0] i_gpio,
   input  logic                  i_spi_miso,
   output logic                  o_ack,
   output logic [`IO_DATA_W-1:0] o_rdata,
   output logic [`IO_GPIO_W-1:0] o_gpio,
   output logic                  o_timer_irq,
   output logic [2:0]            o_ext_irq,
   output logic                  o_spi_sclk,
   output logic                  o_spi_cs_n,
   output logic                  o_spi_mosi
);

   logic                  req_q;
   logic                  acc_q;
   logic                  sel_spi;
   logic                  sys_ack, spi_ack;
   logic [`IO_DATA_W-1:0] sys_rdata, spi_rdata;
   logic                  sw_irq3, sw_irq4, spi_irq;
   logic                  tx_start, busy, push, pop, empty, full;
   logic [7:0]            tx_byte, rx_byte, head_byte;

   // ******************************
   // Strobe launch and slave decode
   // ******************************
   // One request pulse per access, the host holds i_stb until the ack
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         req_q <= 1'b0;
         acc_q <= 1'b0;
      end else begin
         req_q <= i_stb & ~acc_q;
         if (o_ack)
            acc_q <= 1'b0;
         else if (i_stb)
            acc_q <= 1'b1;
      end
   end

   assign sel_spi = i_addr.raw[`IO_SEL_BIT];
   assign o_ack   = sel_spi ? spi_ack : sys_ack;
   assign o_rdata = sel_spi ? spi_rdata : sys_rdata;

   // Bit 0 SPI, bit 1 software 3, bit 2 software 4
   assign o_ext_irq = {sw_irq4, sw_irq3, spi_irq};

   sys_ctrl syscon (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_stb(req_q & ~sel_spi), .i_we(i_we),
      .i_addr(i_addr), .i_wdata(i_wdata), .i_gpio(i_gpio), .o_ack(sys_ack),
      .o_rdata(sys_rdata), .o_gpio(o_gpio), .o_timer_irq(o_timer_irq),
      .o_sw_irq3(sw_irq3), .o_sw_irq4(sw_irq4));

   spi_host_regs spi_regs (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_stb(req_q & sel_spi), .i_we(i_we),
      .i_addr(i_addr), .i_wdata(i_wdata), .i_busy(busy), .i_empty(empty),
      .i_full(full), .i_push(push), .i_rx_data(head_byte), .o_ack(spi_ack),
      .o_rdata(spi_rdata), .o_tx_start(tx_start), .o_tx_byte(tx_byte), .o_pop(pop),
      .o_cs_n(o_spi_cs_n), .o_irq(spi_irq));

   spi_shifter shifter (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_tx_start(tx_start), .i_tx_byte(tx_byte),
      .i_miso(i_spi_miso), .o_busy(busy), .o_push(push), .o_rx_byte(rx_byte),
      .o_sclk(o_spi_sclk), .o_mosi(o_spi_mosi));

   spi_rx_fifo rx_fifo (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(push), .i_data(rx_byte), .i_pop(pop),
      .o_data(head_byte), .o_empty(empty), .o_full(full));

endmodule

/* bench/io_checker.sv */
// Bus monitor with reference model of the system controller and SPI registers
`timescale 1ns/100ps
`include "io_defs.svh"

module io_checker (
   input  logic             i_clk,
   input  logic             i_rst_n,
   input  logic             i_stb,
   input  logic             i_we,
   input  io_pkg::io_addr_u i_addr,
   input  logic [31:0]      i_wdata,
   input  logic [31:0]      i_gpio,
   input  logic             i_ack,
   input  logic [31:0]      i_rdata,
   input  logic [31:0]      i_gpio_out,
   input  logic             i_timer_irq,
   input  logic [2:0]       i_ext_irq,
   input  logic             i_sclk,
   input  logic             i_cs_n,
   output int               o_errors
);

   import io_pkg::*;

   // Cycles the shifter stays busy after the accepting edge, start pulse included
   localparam int XFER_CYCLES = 16 * `IO_SPI_HALF + 1;

   logic [31:0] gpio_m;
   logic [1:0]  swirq_m;
   logic [63:0] mtcmp_m;
   logic [63:0] mtime_m;
   logic        counting;
   logic        irq_exp;
   logic        irq_en_m;
   logic        cs_m;
   logic        wcol_m;
   logic        ovf_m;
   logic [7:0]  tx_m;
   logic [7:0]  rxq[$];
   int          busy_left;
   logic        sclk_prev;
   int          sclk_rises;
   logic        active;
   int          cyc;

   initial o_errors = 0;

   task automatic report_mismatch(input string msg);
      o_errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
   endtask

   task automatic expect_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         report_mismatch($sformatf("%s is 0x%08h, expected 0x%08h", what, got, exp));
   endtask

   // ******************************
   // Read checks
   // ******************************
   task automatic check_sys_read(input logic [63:0] mtime_now);
      case (sys_reg_e'(i_addr.sys.idx))
         GPIO_OUT: expect_word("GPIO_OUT read", i_rdata, gpio_m);
         GPIO_IN:  expect_word("GPIO_IN read", i_rdata, i_gpio);
         MTIME_LO: expect_word("MTIME_LO read", i_rdata, mtime_now[31:0]);
         MTIME_HI: expect_word("MTIME_HI read", i_rdata, mtime_now[63:32]);
         MTCMP_LO: expect_word("MTCMP_LO read", i_rdata, mtcmp_m[31:0]);
         MTCMP_HI: expect_word("MTCMP_HI read", i_rdata, mtcmp_m[63:32]);
         SWIRQ:    expect_word("SWIRQ read", i_rdata, {30'd0, swirq_m});
         default:  expect_word("unmapped read", i_rdata, 32'd0);
      endcase
   endtask

   task automatic check_spi_read(input logic busy_now);
      spi_reg_e r;
      logic     full;
      r    = i_addr.spi.half ? CTRL : spi_reg_e'(i_addr.spi.idx);
      full = (rxq.size() == `IO_FIFO_DEPTH);
      case (r)
         CTRL:   expect_word("CTRL read", i_rdata, {31'd0, irq_en_m});
         STATUS: expect_word("STATUS read", i_rdata,
                             {27'd0, ovf_m, wcol_m, busy_now, full, rxq.size() == 0});
         DATA: begin
            if (rxq.size() > 0) begin
               expect_word("DATA read", i_rdata, {24'd0, rxq[0]});
               void'(rxq.pop_front());
            end
         end
         CS:     expect_word("CS read", i_rdata, {31'd0, cs_m});
         default: expect_word("unmapped SPI read", i_rdata, 32'd0);
      endcase
   endtask

   // ******************************
   // Model update, once per clock
   // ******************************
   always @(negedge i_clk) begin
      int          old_busy;
      logic [63:0] old_mtime;
      logic        started;
      old_busy  = busy_left;
      old_mtime = mtime_m;
      started   = 1'b0;
      if (!i_rst_n) begin
         gpio_m     = '0;
         swirq_m    = 2'b00;
         mtcmp_m    = '1;
         mtime_m    = '0;
         counting   = 1'b0;
         irq_exp    = 1'b0;
         irq_en_m   = 1'b0;
         cs_m       = 1'b1;
         wcol_m     = 1'b0;
         ovf_m      = 1'b0;
         busy_left  = 0;
         sclk_prev  = 1'b0;
         sclk_rises = 0;
         active     = 1'b0;
         cyc        = 0;
         rxq.delete();
      end else begin
         // Timer interrupt is registered, so it follows last cycle's compare
         expect_word("o_timer_irq", {31'd0, i_timer_irq}, {31'd0, irq_exp});
         // MTIME counts every clock from the first edge after reset release
         if (counting)
            mtime_m = mtime_m + 64'd1;
         counting = 1'b1;
         if (i_stb && !active) begin
            active = 1'b1;
            cyc    = 0;
         end else if (active) begin
            cyc++;
         end
         if (i_ack) begin
            if (!active || cyc != 2)
               report_mismatch($sformatf("ack came %0d cycles after strobe, expected 2", cyc));
            if (!i_we) begin
               if (i_addr.raw[`IO_SEL_BIT])
                  check_spi_read(old_busy > 0);
               else
                  check_sys_read(old_mtime);
            end else if (!i_addr.raw[`IO_SEL_BIT]) begin
               case (sys_reg_e'(i_addr.sys.idx))
                  GPIO_OUT: gpio_m = i_wdata;
                  MTCMP_LO: mtcmp_m[31:0] = i_wdata;
                  MTCMP_HI: mtcmp_m[63:32] = i_wdata;
                  SWIRQ:    swirq_m = i_wdata[1:0];
                  default: ;
               endcase
            end else begin
               case (spi_reg_e'(i_addr.spi.idx))
                  CTRL:   irq_en_m = i_wdata[0];
                  STATUS: begin
                     if (i_wdata[3]) wcol_m = 1'b0;
                     if (i_wdata[4]) ovf_m = 1'b0;
                  end
                  DATA: begin
                     if (old_busy > 0) begin
                        wcol_m = 1'b1;
                     end else begin
                        tx_m    = i_wdata[7:0];
                        started = 1'b1;
                     end
                  end
                  CS:     cs_m = i_wdata[0];
                  default: ;
               endcase
            end
         end
         if (!i_stb)
            active = 1'b0;
         if (i_sclk && !sclk_prev)
            sclk_rises++;
         sclk_prev = i_sclk;
         // MISO loops back, so the received byte is the one sent
         if (started) begin
            busy_left  = XFER_CYCLES;
            sclk_rises = 0;
         end else if (old_busy > 0) begin
            busy_left = old_busy - 1;
            if (busy_left == 0) begin
               if (sclk_rises != 8)
                  report_mismatch($sformatf("%0d SCLK rising edges in one byte, expected 8",
                                            sclk_rises));
               if (rxq.size() == `IO_FIFO_DEPTH)
                  ovf_m = 1'b1;
               else
                  rxq.push_back(tx_m);
            end
         end
         // Mode 0 idles with SCLK low
         if (busy_left == 0)
            expect_word("o_spi_sclk while idle", {31'd0, i_sclk}, 32'd0);
         irq_exp = (mtime_m >= mtcmp_m);
         expect_word("o_gpio", i_gpio_out, gpio_m);
         expect_word("o_spi_cs_n", {31'd0, i_cs_n}, {31'd0, cs_m});
         expect_word("o_ext_irq", {29'd0, i_ext_irq},
                     {29'd0, swirq_m, irq_en_m & (rxq.size() > 0)});
      end
   end

endmodule

/* bench/tb_io_subsys.sv */
// Testbench top with clock, reset, xorshift bus stimulus, DUT and checker instances
`timescale 1ns/100ps
`include "io_defs.svh"

module tb_io_subsys;

   import io_pkg::*;

   logic        clk;
   logic        rst_n;
   logic        stb;
   logic        we;
   io_addr_u    addr;
   logic [31:0] wdata;
   logic [31:0] gpio_in;
   logic        ack;
   logic [31:0] rdata;
   logic [31:0] gpio_out;
   logic        timer_irq;
   logic [2:0]  ext_irq;
   logic        sclk;
   logic        cs_n;
   logic        mosi;
   int          chk_errors;
   logic [31:0] rng_state = 32'd11;

   initial clk = 1'b0;
   always #20 clk = ~clk;

   io_subsys_top UUT (
      .i_clk(clk), .i_rst_n(rst_n), .i_stb(stb), .i_we(we), .i_addr(addr),
      .i_wdata(wdata), .i_gpio(gpio_in), .i_spi_miso(mosi), .o_ack(ack),
      .o_rdata(rdata), .o_gpio(gpio_out), .o_timer_irq(timer_irq),
      .o_ext_irq(ext_irq), .o_spi_sclk(sclk), .o_spi_cs_n(cs_n), .o_spi_mosi(mosi));

   io_checker chk (
      .i_clk(clk), .i_rst_n(rst_n), .i_stb(stb), .i_we(we), .i_addr(addr),
      .i_wdata(wdata), .i_gpio(gpio_in), .i_ack(ack), .i_rdata(rdata),
      .i_gpio_out(gpio_out), .i_timer_irq(timer_irq), .i_ext_irq(ext_irq),
      .i_sclk(sclk), .i_cs_n(cs_n), .o_errors(chk_errors));

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [7:0] sys_addr(input sys_reg_e r);
      return {3'b000, r, 2'b00};
   endfunction

   function automatic logic [7:0] spi_addr(input spi_reg_e r, input logic half);
      return {2'b10, r, half, 2'b00};
   endfunction

   task automatic abort_run(input string msg);
      $display("Timeout: %s", msg);
      $display("ERRORS FOUND");
      $finish;
   endtask

   // ******************************
   // Host bus access
   // ******************************
   task automatic bus_access(input logic w, input logic [7:0] a, input logic [31:0] d,
                             output logic [31:0] q);
      int n;
      stb      = 1'b1;
      we       = w;
      addr.raw = a;
      wdata    = d;
      n        = 0;
      do begin
         @(posedge clk);
         #2;
         n++;
      end while (!ack && n < 8);
      if (!ack)
         abort_run($sformatf("no ack for access to address 0x%02h", a));
      q = rdata;
      @(posedge clk);
      #2;
      stb = 1'b0;
      we  = 1'b0;
      @(posedge clk);
      #2;
   endtask

   task automatic bus_write(input logic [7:0] a, input logic [31:0] d);
      logic [31:0] unused;
      bus_access(1'b1, a, d, unused);
   endtask

   task automatic bus_read(input logic [7:0] a, output logic [31:0] q);
      bus_access(1'b0, a, 32'd0, q);
   endtask

   task automatic wait_spi_idle();
      logic [31:0] s;
      int          n;
      n = 0;
      do begin
         bus_read(spi_addr(STATUS, 1'b0), s);
         n++;
      end while (s[2] && n < 40);
      if (s[2])
         abort_run("SPI shifter stayed busy past the poll limit");
   endtask

   initial begin
      logic [31:0] d;
      logic [31:0] r;
      logic [31:0] t1;
      int          off;
      int          n;
      rst_n   = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      addr    = '0;
      wdata   = '0;
      gpio_in = '0;
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(posedge clk);
      #2;

      // GPIO and software interrupts
      for (int i = 0; i < 40; i++) begin
         r = next_rand();
         case (r[1:0])
            2'd0: bus_write(sys_addr(GPIO_OUT), next_rand());
            2'd1: bus_write(sys_addr(SWIRQ), next_rand());
            2'd2: bus_read(sys_addr(r[2] ? GPIO_OUT : SWIRQ), d);
            default: begin
               gpio_in = next_rand();
               bus_read(sys_addr(GPIO_IN), d);
            end
         endcase
      end

      // ******************************
      // Timer and compare
      // ******************************
      bus_read(sys_addr(MTIME_LO), d);
      bus_read(sys_addr(MTIME_LO), t1);
      bus_read(sys_addr(MTIME_HI), d);
      off = 20 + int'(next_rand() % 32);
      bus_write(sys_addr(MTCMP_HI), d);
      bus_write(sys_addr(MTCMP_LO), t1 + off);
      n = 0;
      while (!timer_irq && n < off + 40) begin
         @(posedge clk);
         #2;
         n++;
      end
      if (!timer_irq)
         abort_run("timer interrupt never rose after the compare was set");

      // SPI loopback, single bytes
      bus_write(spi_addr(CTRL, 1'b0), 32'h1);
      bus_write(spi_addr(CS, 1'b0), 32'h0);
      for (int i = 0; i < 6; i++) begin
         bus_write(spi_addr(DATA, 1'b0), next_rand());
         wait_spi_idle();
         bus_read(spi_addr(DATA, 1'b0), d);
         bus_read(spi_addr(STATUS, 1'b0), d);
      end

      // Upper half reads must not pop
      bus_write(spi_addr(DATA, 1'b0), next_rand());
      wait_spi_idle();
      for (int i = 0; i < 6; i++) begin
         r = next_rand();
         bus_read(spi_addr(spi_reg_e'(r[1:0]), 1'b1), d);
      end
      bus_read(spi_addr(STATUS, 1'b0), d);
      bus_read(spi_addr(DATA, 1'b0), d);

      // ******************************
      // Overflow and write collision
      // ******************************
      for (int i = 0; i < 5; i++) begin
         bus_write(spi_addr(DATA, 1'b0), next_rand());
         wait_spi_idle();
      end
      bus_read(spi_addr(STATUS, 1'b0), d);
      for (int i = 0; i < 4; i++)
         bus_read(spi_addr(DATA, 1'b0), d);
      bus_read(spi_addr(STATUS, 1'b0), d);
      bus_write(spi_addr(STATUS, 1'b0), 32'h10);
      bus_read(spi_addr(STATUS, 1'b0), d);
      bus_write(spi_addr(DATA, 1'b0), next_rand());
      bus_write(spi_addr(DATA, 1'b0), next_rand());
      wait_spi_idle();
      bus_read(spi_addr(STATUS, 1'b0), d);
      bus_write(spi_addr(STATUS, 1'b0), 32'h08);
      bus_read(spi_addr(STATUS, 1'b0), d);
      bus_read(spi_addr(DATA, 1'b0), d);
      bus_read(spi_addr(STATUS, 1'b0), d);
      bus_write(spi_addr(CS, 1'b0), 32'h1);
      bus_read(spi_addr(CS, 1'b0), d);

      @(posedge clk);
      #2;
      $display("Run finished with %0d checker errors", chk_errors);
      if (chk_errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* flist.f */
+incdir+verilog
verilog/io_pkg.sv
verilog/sys_ctrl.sv
verilog/spi_shifter.sv
verilog/spi_rx_fifo.sv
verilog/spi_host_regs.sv
verilog/io_subsys_top.sv
bench/io_checker.sv
bench/tb_io_subsys.sv

/* run.sh */
#!/usr/bin/env bash
# Build the IO subsystem testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal +incdir+verilog -f flist.f \
   --top-module tb_io_subsys -o sim_io_subsys \
   && out="$(./obj_dir/sim_io_subsys)" \
   && echo "$out" \
   && echo "$out" | grep -qx "NO ERRORS" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
